/* dv/dnc_allocation_tb.sv */
// DNC allocation weighting testbench
module dnc_allocation_tb;

  localparam int DATA_SIZE  = 16;
  localparam int FRAC_BITS  = 15;
  localparam int SIZE_N_MAX = 16;
  localparam int EXP_DEPTH  = 256;
  localparam logic [DATA_SIZE-1:0] ONE = DATA_SIZE'(1 << FRAC_BITS);

  ////////////////////////////////////////////////////////////
  // DUT and clock
  ////////////////////////////////////////////////////////////

  logic                 CLK;
  logic                 RST;
  logic                 START;
  logic                 U_IN_ENABLE;
  logic [DATA_SIZE-1:0] SIZE_N_IN;
  logic [DATA_SIZE-1:0] U_IN;
  logic                 READY;
  logic                 A_OUT_ENABLE;
  logic [DATA_SIZE-1:0] A_OUT;

  dnc_allocation_top dnc_allocation_top_i (
    .CLK         (CLK),
    .RST         (RST),
    .START       (START),
    .U_IN_ENABLE (U_IN_ENABLE),
    .SIZE_N_IN   (SIZE_N_IN),
    .U_IN        (U_IN),
    .READY       (READY),
    .A_OUT_ENABLE(A_OUT_ENABLE),
    .A_OUT       (A_OUT)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////
  // Scoreboard state
  ////////////////////////////////////////////////////////////

  integer               seed = 32'ha52c4ef7;
  logic [DATA_SIZE-1:0] u_vec [SIZE_N_MAX];

  // Expected beats in output order, last flags mark vector ends
  logic [DATA_SIZE-1:0] exp_buf  [EXP_DEPTH];
  logic                 exp_last [EXP_DEPTH];
  logic [DATA_SIZE-1:0] got_buf  [EXP_DEPTH];
  int                   wr_ptr = 0;
  int                   rd_ptr;
  logic [DATA_SIZE-1:0] exp_a;
  logic                 exp_last_a;

  int                   ready_count;
  int                   ready_goal = 0;
  logic                 started = 1'b0;

  string                test_name = "reset";
  int                   err_count = 0;
  int                   test_count = 0;
  int                   fail_count = 0;
  int                   test_err_base = 0;

  assign exp_a      = exp_buf[rd_ptr];
  assign exp_last_a = exp_last[rd_ptr];

  // Capture beats and READY pulses
  always @(posedge CLK or posedge RST) begin
    if (RST) begin
      rd_ptr      <= 0;
      ready_count <= 0;
    end else begin
      if (A_OUT_ENABLE) begin
        got_buf[rd_ptr] <= A_OUT;
        rd_ptr          <= rd_ptr + 1;
      end
      if (READY) begin
        ready_count <= ready_count + 1;
      end
    end
  end

  task automatic report_mismatch(input logic [DATA_SIZE-1:0] expected,
                                 input logic [DATA_SIZE-1:0] actual);
    err_count++;
    $display("error %s: expected %h, actual %h", test_name, expected, actual);
  endtask

  task automatic flag_failure(input string what);
    err_count++;
    $display("error in %s: %s", test_name, what);
  endtask

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Quiet outputs until the first START
  assert property (@(posedge CLK) disable iff (RST) !started |-> (!READY && !A_OUT_ENABLE))
    else flag_failure("output active before the first START");

  assert property (@(posedge CLK) disable iff (RST) A_OUT_ENABLE |-> (rd_ptr < wr_ptr))
    else flag_failure("A_OUT beat with no vector pending");

  // Slot-ordered value against the reference model
  assert property (@(posedge CLK) disable iff (RST) A_OUT_ENABLE |-> (A_OUT == exp_a))
    else report_mismatch($sampled(exp_a), $sampled(A_OUT));

  // N back-to-back beats
  assert property (@(posedge CLK) disable iff (RST)
                   (A_OUT_ENABLE && !exp_last_a) |=> A_OUT_ENABLE)
    else flag_failure("A_OUT_ENABLE dropped before the vector ended");

  // READY right after the last beat, stream stopped
  assert property (@(posedge CLK) disable iff (RST)
                   (A_OUT_ENABLE && exp_last_a) |=> (READY && !A_OUT_ENABLE))
    else flag_failure("no READY, or A_OUT_ENABLE still high, after the last beat");

  // One pulse only
  assert property (@(posedge CLK) disable iff (RST) READY |-> $past(A_OUT_ENABLE && exp_last_a))
    else flag_failure("READY pulse not right after a last beat");

  ////////////////////////////////////////////////////////////
  // Reference model and drivers
  ////////////////////////////////////////////////////////////

  function automatic int vector_cycles(input int n);
    return n * (n + 2) + 2 * n + 20;
  endfunction

  task automatic fill_random(input int n);
    for (int k = 0; k < n; k++) begin
      u_vec[k] = DATA_SIZE'($unsigned($random(seed)) % (int'(ONE) + 1));
    end
  endtask

  // Stable sort, exclusive product, scatter back by slot
  task automatic push_expected(input int n);
    int                   order [SIZE_N_MAX];
    logic [DATA_SIZE-1:0] a_ref [SIZE_N_MAX];
    longint               prod;
    longint               w;
    int                   j;
    // Insertion only moves past strictly larger usages
    for (int i = 0; i < n; i++) begin
      j = i;
      while (j > 0 && u_vec[order[j-1]] > u_vec[i]) begin
        order[j] = order[j-1];
        j--;
      end
      order[j] = i;
    end
    prod = longint'(1) << FRAC_BITS;
    for (int k = 0; k < n; k++) begin
      w = (((longint'(1) << FRAC_BITS) - longint'(u_vec[order[k]])) * prod) >> FRAC_BITS;
      a_ref[order[k]] = DATA_SIZE'(w);
      prod = (prod * longint'(u_vec[order[k]])) >> FRAC_BITS;
    end
    for (int k = 0; k < n; k++) begin
      exp_buf[wr_ptr]  = a_ref[k];
      exp_last[wr_ptr] = (k == n - 1);
      wr_ptr++;
    end
  endtask

  // START at the current edge, then u_vec with random gaps
  // Returns on the edge that takes the last usage
  task automatic run_vector(input int n, input bit poke_start);
    int k;
    int beat;
    START     <= 1'b1;
    SIZE_N_IN <= DATA_SIZE'(n);
    started   <= 1'b1;
    @(posedge CLK);
    START <= 1'b0;
    k     = 0;
    beat  = 0;
    while (k < n) begin
      if (($random(seed) & 3) == 0) begin
        U_IN_ENABLE <= 1'b0;
      end else begin
        U_IN_ENABLE <= 1'b1;
        U_IN        <= u_vec[k];
        k++;
      end
      // Stray START while the sorter loads
      START <= poke_start && (beat == 2);
      beat++;
      @(posedge CLK);
    end
    U_IN_ENABLE <= 1'b0;
    START       <= 1'b0;
    push_expected(n);
    ready_goal++;
  endtask

  task automatic wait_ready(input int limit);
    int waited;
    waited = 0;
    while (ready_count < ready_goal && waited < limit) begin
      @(posedge CLK);
      waited++;
    end
    if (ready_count < ready_goal) begin
      flag_failure($sformatf("READY did not arrive within %0d cycles", limit));
    end
  endtask

  task automatic begin_test(input string name);
    test_name     = name;
    test_err_base = err_count;
  endtask

  task automatic end_test();
    test_count++;
    if (err_count == test_err_base) begin
      $display("test %s: pass", test_name);
    end else begin
      fail_count++;
      $display("test %s: fail, %0d mismatches", test_name, err_count - test_err_base);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  initial begin
    int base;
    RST         = 1'b1;
    START       = 1'b0;
    U_IN_ENABLE = 1'b0;
    SIZE_N_IN   = '0;
    U_IN        = '0;
    repeat (4) @(posedge CLK);
    RST <= 1'b0;

    begin_test("reset_quiet");
    repeat (10) @(posedge CLK);
    end_test();

    // Weight is one minus u
    begin_test("single_slot");
    fill_random(1);
    base = wr_ptr;
    run_vector(1, 1'b0);
    wait_ready(vector_cycles(1));
    assert (got_buf[base] == ONE - u_vec[0])
      else report_mismatch(ONE - u_vec[0], got_buf[base]);
    end_test();

    for (int n = 1; n <= SIZE_N_MAX; n++) begin
      begin_test($sformatf("random_n%0d", n));
      fill_random(n);
      run_vector(n, 1'b0);
      wait_ready(vector_cycles(n));
      end_test();
    end

    begin_test("ties_extremes");
    // Three-way tie at 0.75, two slots full
    u_vec[0] = 16'h6000;
    u_vec[1] = 16'h2000;
    u_vec[2] = 16'h6000;
    u_vec[3] = ONE;
    u_vec[4] = 16'h6000;
    u_vec[5] = ONE;
    base = wr_ptr;
    run_vector(6, 1'b0);
    wait_ready(vector_cycles(6));
    assert (got_buf[base] > got_buf[base+2] && got_buf[base+2] > got_buf[base+4])
      else flag_failure("tied usages did not favour the lower slot");
    assert (got_buf[base+3] == '0 && got_buf[base+5] == '0)
      else flag_failure("full slot got a nonzero weight");
    // Empty slot sorts first, everything after it is zero
    u_vec[0] = 16'h7000;
    u_vec[1] = 16'h0000;
    u_vec[2] = 16'h3000;
    u_vec[3] = ONE;
    base = wr_ptr;
    run_vector(4, 1'b0);
    wait_ready(vector_cycles(4));
    assert (got_buf[base+1] == ONE)
      else report_mismatch(ONE, got_buf[base+1]);
    end_test();

    // Second START the cycle the sorter goes idle
    begin_test("back_to_back");
    fill_random(6);
    run_vector(6, 1'b1);
    repeat (6 * 7) @(posedge CLK);
    fill_random(7);
    run_vector(7, 1'b0);
    wait_ready(vector_cycles(6) + vector_cycles(7));
    end_test();

    $display("tests %0d, failed %0d, mismatches %0d", test_count, fail_count, err_count);
    if (err_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog, twice the worst case of all vectors
  initial begin
    int budget;
    budget = 14 + vector_cycles(1) + vector_cycles(6) + vector_cycles(4);
    budget = budget + vector_cycles(6) + vector_cycles(7);
    for (int n = 1; n <= SIZE_N_MAX; n++) begin
      budget = budget + vector_cycles(n);
    end
    budget = budget * 2;
    repeat (budget) @(posedge CLK);
    $display("watchdog: run still going after %0d cycles in %s", budget, test_name);
    $display("Errors found");
    $finish;
  end

endmodule

/* hdl/dnc_allocation_top.sv */
// DNC allocation weighting top level
module dnc_allocation_top #(
  parameter int DATA_SIZE  = 16,
  parameter int FRAC_BITS  = 15,
  parameter int SIZE_N_MAX = 16
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  logic                 U_IN_ENABLE,
  input  logic [DATA_SIZE-1:0] SIZE_N_IN,
  input  logic [DATA_SIZE-1:0] U_IN,
  output logic                 READY,
  output logic                 A_OUT_ENABLE,
  output logic [DATA_SIZE-1:0] A_OUT
);

  // Sorter to chain, rising usage order
  dnc_stream_if #(.DATA_SIZE(DATA_SIZE), .SIZE_N_MAX(SIZE_N_MAX)) sorted_s ();
  // Chain to streamer, weights still in sorted order
  dnc_stream_if #(.DATA_SIZE(DATA_SIZE), .SIZE_N_MAX(SIZE_N_MAX)) weight_s ();

  // Free list
  dnc_sort_vector #(.DATA_SIZE(DATA_SIZE), .SIZE_N_MAX(SIZE_N_MAX)) sort_vector_i (
    .CLK        (CLK),
    .RST        (RST),
    .START      (START),
    .SIZE_N_IN  (SIZE_N_IN),
    .U_IN_ENABLE(U_IN_ENABLE),
    .U_IN       (U_IN),
    .sorted     (sorted_s.source)
  );

  // Per-position weights
  dnc_weight_chain #(.DATA_SIZE(DATA_SIZE), .FRAC_BITS(FRAC_BITS)) weight_chain_i (
    .CLK   (CLK),
    .RST   (RST),
    .sorted(sorted_s.sink),
    .weight(weight_s.source)
  );

  // Slot order out
  dnc_allocation_weighting #(.DATA_SIZE(DATA_SIZE), .SIZE_N_MAX(SIZE_N_MAX)) weighting_i (
    .CLK         (CLK),
    .RST         (RST),
    .weight      (weight_s.sink),
    .A_OUT_ENABLE(A_OUT_ENABLE),
    .A_OUT       (A_OUT),
    .READY       (READY)
  );

endmodule

/* hdl/dnc_allocation_weighting.sv */
// Allocation weight output streamer
module dnc_allocation_weighting #(
  parameter int DATA_SIZE  = 16,
  parameter int SIZE_N_MAX = 16
) (
  input  logic                 CLK,
  input  logic                 RST,
  dnc_stream_if.sink           weight,
  output logic                 A_OUT_ENABLE,
  output logic [DATA_SIZE-1:0] A_OUT,
  output logic                 READY
);

  import dnc_pkg::*;

  localparam int INDEX_SIZE = (SIZE_N_MAX > 1) ? $clog2(SIZE_N_MAX) : 1;
  localparam int COUNT_SIZE = $clog2(SIZE_N_MAX + 1);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  // FSM
  out_phase_t            phase;

  // Beats seen in the current vector
  logic [COUNT_SIZE-1:0] beat_count;

  // N learned from the last beat
  logic [COUNT_SIZE-1:0] size_n;
  logic [INDEX_SIZE-1:0] last_index;

  // Drain pointer in slot order
  logic [INDEX_SIZE-1:0] read_index;

  // Weights by slot
  logic [DATA_SIZE-1:0]  a_mem [SIZE_N_MAX];

  ////////////////////////////////////////////////////////////
  // Body
  ////////////////////////////////////////////////////////////

  assign last_index = INDEX_SIZE'(size_n - COUNT_SIZE'(1));

  // Control
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      phase      <= COLLECT;
      beat_count <= '0;
      size_n     <= '0;
      read_index <= '0;
      READY      <= 1'b0;
    end else begin
      // Single-cycle pulse
      READY <= 1'b0;

      case (phase)
        COLLECT: begin
          if (weight.valid) begin
            if (weight.last) begin
              // Count includes this beat
              size_n     <= beat_count + COUNT_SIZE'(1);
              beat_count <= '0;
              read_index <= '0;
              phase      <= DRAIN;
            end else begin
              beat_count <= beat_count + COUNT_SIZE'(1);
            end
          end
        end

        DRAIN: begin
          // N back-to-back beats then READY
          if (read_index == last_index) begin
            READY <= 1'b1;
            phase <= COLLECT;
          end else begin
            read_index <= read_index + 1'b1;
          end
        end

        default: phase <= COLLECT;
      endcase
    end
  end

  // Scatter into slot order
  // Only the slot index matters here
  always_ff @(posedge CLK) begin
    if ((phase == COLLECT) && weight.valid) begin
      a_mem[weight.index] <= weight.value;
    end
  end

  // Output beats straight from the buffer
  assign A_OUT_ENABLE = (phase == DRAIN);
  assign A_OUT        = a_mem[read_index];

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // Next vector must wait for the drain
  // Its load alone takes N cycles, so the sorter EMIT cannot land here
  assert property (@(posedge CLK) disable iff (RST) weight.valid |-> (phase == COLLECT))
    else $error("weight beat in DRAIN, sorter EMIT overlapped the output stream");

  // Sorter framing closes every vector in time
  assert property (@(posedge CLK) disable iff (RST)
                   (weight.valid && !weight.last) |-> (beat_count < COUNT_SIZE'(SIZE_N_MAX - 1)))
    else $error("no last beat within %0d weights", SIZE_N_MAX);

endmodule

/* hdl/dnc_pkg.sv */
// DNC allocation shared definitions
package dnc_pkg;

  ////////////////////////////////////////////////////////////
  // Fixed point
  ////////////////////////////////////////////////////////////

  // Widest value the helpers carry
  localparam int Q_WORD_SIZE = 64;

  // Unsigned Q word, callers cut it back to their own width
  typedef logic [Q_WORD_SIZE-1:0] q_word_t;

  // Value one, 2^frac_bits
  function automatic q_word_t q_one(input int frac_bits);
    return q_word_t'(1) << frac_bits;
  endfunction

  // Truncating product
  // Full double width first, then drop the fraction bits
  function automatic q_word_t q_mul(input q_word_t a, input q_word_t b, input int frac_bits);
    logic [2*Q_WORD_SIZE-1:0] full;
    full = a * b;
    return q_word_t'(full >> frac_bits);
  endfunction

  ////////////////////////////////////////////////////////////
  // Controller phases
  ////////////////////////////////////////////////////////////

  // Sorter FSM
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    LOAD = 2'd1,
    SCAN = 2'd2,
    EMIT = 2'd3
  } sort_phase_t;

  // Output streamer FSM
  typedef enum logic {
    COLLECT = 1'b0,
    DRAIN   = 1'b1
  } out_phase_t;

endpackage

/* hdl/dnc_sort_vector.sv */
// Stable usage sorter
module dnc_sort_vector #(
  parameter int DATA_SIZE  = 16,
  parameter int SIZE_N_MAX = 16
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  logic [DATA_SIZE-1:0] SIZE_N_IN,
  input  logic                 U_IN_ENABLE,
  input  logic [DATA_SIZE-1:0] U_IN,
  dnc_stream_if.source         sorted
);

  import dnc_pkg::*;

  localparam int INDEX_SIZE = (SIZE_N_MAX > 1) ? $clog2(SIZE_N_MAX) : 1;
  localparam int COUNT_SIZE = $clog2(SIZE_N_MAX + 1);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  // FSM
  sort_phase_t           phase;

  // Vector length, latched with START
  logic [COUNT_SIZE-1:0] size_n;
  logic [INDEX_SIZE-1:0] last_index;

  // Counters
  logic [INDEX_SIZE-1:0] load_index;
  logic [INDEX_SIZE-1:0] scan_index;
  logic [INDEX_SIZE-1:0] emit_count;

  // Slots already emitted
  logic [SIZE_N_MAX-1:0] taken;

  // Usage store
  logic [DATA_SIZE-1:0]  u_mem [SIZE_N_MAX];

  // Running minimum of the current scan
  logic                  best_found;
  logic [INDEX_SIZE-1:0] best_index;
  logic [DATA_SIZE-1:0]  best_value;
  logic                  candidate;

  ////////////////////////////////////////////////////////////
  // Body
  ////////////////////////////////////////////////////////////

  assign last_index = INDEX_SIZE'(size_n - COUNT_SIZE'(1));

  // Free slot that beats the minimum so far
  // Strictly smaller only, so ties stay with the lower slot
  assign candidate = !taken[scan_index] &&
                     (!best_found || (u_mem[scan_index] < best_value));

  // Control
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      phase      <= IDLE;
      size_n     <= '0;
      load_index <= '0;
      scan_index <= '0;
      emit_count <= '0;
      taken      <= '0;
      best_found <= 1'b0;
    end else begin
      case (phase)
        IDLE: begin
          // START ignored anywhere else
          if (START) begin
            size_n     <= SIZE_N_IN[COUNT_SIZE-1:0];
            load_index <= '0;
            taken      <= '0;
            phase      <= LOAD;
          end
        end

        LOAD: begin
          if (U_IN_ENABLE) begin
            load_index <= load_index + 1'b1;
            if (load_index == last_index) begin
              scan_index <= '0;
              emit_count <= '0;
              best_found <= 1'b0;
              phase      <= SCAN;
            end
          end
        end

        SCAN: begin
          // One slot per cycle, N cycles per position
          if (candidate) begin
            best_found <= 1'b1;
          end
          scan_index <= scan_index + 1'b1;
          if (scan_index == last_index) begin
            phase <= EMIT;
          end
        end

        EMIT: begin
          // Winner leaves the pool
          taken[best_index] <= 1'b1;
          best_found        <= 1'b0;
          scan_index        <= '0;
          emit_count        <= emit_count + 1'b1;
          if (emit_count == last_index) begin
            phase <= IDLE;
          end else begin
            phase <= SCAN;
          end
        end

        default: phase <= IDLE;
      endcase
    end
  end

  // Store and minimum payload
  always_ff @(posedge CLK) begin
    if ((phase == LOAD) && U_IN_ENABLE) begin
      u_mem[load_index] <= U_IN;
    end
    if ((phase == SCAN) && candidate) begin
      best_index <= scan_index;
      best_value <= u_mem[scan_index];
    end
  end

  // Sorted stream, one beat per EMIT cycle
  assign sorted.valid = (phase == EMIT);
  assign sorted.last  = (phase == EMIT) && (emit_count == last_index);
  assign sorted.index = best_index;
  assign sorted.value = best_value;

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // Loader only drives usages after START
  assert property (@(posedge CLK) disable iff (RST) U_IN_ENABLE |-> (phase == LOAD))
    else $error("U_IN_ENABLE high outside LOAD");

  // Emitted slot lies inside the latched vector
  assert property (@(posedge CLK) disable iff (RST) sorted.valid |-> (sorted.index < size_n))
    else $error("sorted index %0d not below N %0d", sorted.index, size_n);

endmodule

/* hdl/dnc_stream_if.sv */
// Indexed value stream
interface dnc_stream_if #(
  parameter int DATA_SIZE  = 16,
  parameter int SIZE_N_MAX = 16
) ();

  // Slot number width, one bit at least
  localparam int INDEX_SIZE = (SIZE_N_MAX > 1) ? $clog2(SIZE_N_MAX) : 1;

  // One beat per cycle, no stall
  logic                  valid;
  // Final beat of a vector
  logic                  last;
  // Slot the value belongs to
  logic [INDEX_SIZE-1:0] index;
  logic [DATA_SIZE-1:0]  value;

  // Producer side
  modport source (
    output valid,
    output last,
    output index,
    output value
  );

  // Consumer side
  modport sink (
    input valid,
    input last,
    input index,
    input value
  );

endinterface

/* hdl/dnc_weight_chain.sv */
// Exclusive product weight chain
module dnc_weight_chain #(
  parameter int DATA_SIZE = 16,
  parameter int FRAC_BITS = 15
) (
  input  logic          CLK,
  input  logic          RST,
  dnc_stream_if.sink    sorted,
  dnc_stream_if.source  weight
);

  import dnc_pkg::*;

  // Fixed-point one at this width
  localparam logic [DATA_SIZE-1:0] Q_ONE = DATA_SIZE'(q_one(FRAC_BITS));

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  // Product of usages already passed in this vector
  logic [DATA_SIZE-1:0] run_prod;

  logic [DATA_SIZE-1:0] one_minus_u;
  logic [DATA_SIZE-1:0] weight_next;
  logic [DATA_SIZE-1:0] prod_next;

  ////////////////////////////////////////////////////////////
  // Body
  ////////////////////////////////////////////////////////////

  // Free fraction of the slot
  assign one_minus_u = Q_ONE - sorted.value;

  // (1 - u) times everything sorted before it
  assign weight_next = DATA_SIZE'(q_mul(q_word_t'(one_minus_u), q_word_t'(run_prod),
                                        FRAC_BITS));

  // Fold this usage in for the next position
  assign prod_next = DATA_SIZE'(q_mul(q_word_t'(run_prod), q_word_t'(sorted.value),
                                      FRAC_BITS));

  // Control and running product
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      run_prod     <= Q_ONE;
      weight.valid <= 1'b0;
      weight.last  <= 1'b0;
    end else begin
      weight.valid <= sorted.valid;
      weight.last  <= sorted.valid && sorted.last;
      if (sorted.valid) begin
        // Back to one for the next vector
        run_prod <= sorted.last ? Q_ONE : prod_next;
      end
    end
  end

  // Beat payload, one cycle behind the input
  always_ff @(posedge CLK) begin
    if (sorted.valid) begin
      weight.index <= sorted.index;
      weight.value <= weight_next;
    end
  end

  // Usages stay in [0, 1] all the way from the loader
  assert property (@(posedge CLK) disable iff (RST) sorted.valid |-> (sorted.value <= Q_ONE))
    else $error("usage %0h above one at slot %0d", sorted.value, sorted.index);

endmodule

/* run.sh */
#!/bin/sh
# Build and run the allocation testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module dnc_allocation_tb -o sim_dnc_allocation

out=$(./obj_dir/sim_dnc_allocation)
echo "$out"
echo "$out" | grep -q "No errors"

/* tb.f */
hdl/dnc_pkg.sv
hdl/dnc_stream_if.sv
hdl/dnc_sort_vector.sv
hdl/dnc_weight_chain.sv
hdl/dnc_allocation_weighting.sv
hdl/dnc_allocation_top.sv
dv/dnc_allocation_tb.sv
